/* verilog/merge_pkg.sv */
// ##########################################################
// merge package
// shared sample width, FIFO depth and the enums of the
// dual-channel sample merger
// ##########################################################

package merge_pkg;

  // datapath
  localparam int sample_width = 16;    // bits per sample

  // channel FIFO sizing
  localparam int fifo_depth_log2 = 4;  // 16-word RAM, 15 words usable

  // source channel tag, travels with every delivered sample
  typedef enum logic {
    ch0 = 1'b0,                        // first source
    ch1 = 1'b1                         // second source
  } chan_e;

  // merger handshake FSM
  typedef enum logic [1:0] {
    idle         = 2'd0,               // free to pick a channel
    req_high     = 2'd1,               // sample offered, waiting for ack
    wait_ack_low = 2'd2                // req dropped, waiting for ack release
  } merge_state_e;

endpackage

/* verilog/fifo_1cycle.sv */
`timescale 1ns/1ps
// ##########################################################
// single-cycle-latency FIFO, one clock for both sides
// registered-write RAM with asynchronous read port,
// registered fill count, drop-on-full with sticky overflow
// ##########################################################

module fifo_1cycle #(
  parameter int data_width = merge_pkg::sample_width,    // word width
  parameter int depth_log2 = merge_pkg::fifo_depth_log2  // address width
) (
  input  logic                  clk,
  input  logic                  rst,       // async, active high
  input  logic                  we,        // write strobe from source
  input  logic                  re,        // read strobe, only when nempty
  input  logic [data_width-1:0] data_in,   // write data
  output logic [data_width-1:0] data_out,  // word at read pointer, no register
  output logic                  nempty,    // at least one word held
  output logic                  overflow   // sticky, set by a refused write
);

  logic [depth_log2-1:0] wa;          // write address
  logic [depth_log2-1:0] ra;          // read address
  logic [depth_log2-1:0] fill;        // words held, max all ones
  logic [depth_log2-1:0] next_fill;   // fill after this edge
  logic                  full;        // no free slot without a read
  logic                  wr_ok;       // write actually accepted

  logic [data_width-1:0] ram [0:(1<<depth_log2)-1];

  // one RAM word always stays free, so all-ones fill means full
  assign full  = &fill;
  assign wr_ok = we && (!full || re);  // same-cycle read frees a slot

  always_comb begin
    next_fill = fill;                  // write and read together, or neither
    if (wr_ok && !re) begin
      next_fill = fill + 1'b1;
    end else if (!wr_ok && re) begin
      next_fill = fill - 1'b1;
    end
  end

  // pointers, fill and flags
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wa       <= '0;
      ra       <= '0;
      fill     <= '0;
      nempty   <= 1'b0;
      overflow <= 1'b0;
    end else begin
      fill   <= next_fill;
      nempty <= (next_fill != '0);     // high right after the first write
      if (wr_ok) begin
        wa <= wa + 1'b1;
      end
      if (re) begin
        ra <= ra + 1'b1;
      end else if (fill == '0) begin
        ra <= wa;                      // resync read side while empty
      end
      if (we && !wr_ok) begin
        overflow <= 1'b1;              // sample dropped, held until reset
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      ram[wa] <= data_in;
    end
  end

  assign data_out = ram[ra];           // async read

  // the merger must never pull from a channel it did not see as non-empty
  a_no_underrun: assert property (
    @(posedge clk) disable iff (rst)
    re |-> nempty
  );

  // a full FIFO can only stay full or drain by one, never wrap to zero
  a_fill_no_wrap: assert property (
    @(posedge clk) disable iff (rst)
    full |=> (fill != '0)
  );

endmodule

/* verilog/channel_merger.sv */
`timescale 1ns/1ps
// ##########################################################
// channel merger
// round-robin pick between two FIFOs, tags the sample with
// its channel and offers it over a four-phase req/ack
// ##########################################################

module channel_merger (
  input  logic                              clk,
  input  logic                              rst,       // async, active high
  input  logic                              nempty0,   // ch0 FIFO holds data
  input  logic                              nempty1,   // ch1 FIFO holds data
  input  logic [merge_pkg::sample_width-1:0] data0,    // ch0 FIFO head
  input  logic [merge_pkg::sample_width-1:0] data1,    // ch1 FIFO head
  output logic                              re0,       // pop ch0, one cycle
  output logic                              re1,       // pop ch1, one cycle
  output logic                              out_req,   // sample offered
  input  logic                              out_ack,   // consumer answer
  output logic [merge_pkg::sample_width-1:0] out_data, // held while out_req
  output merge_pkg::chan_e                  out_chan   // source of out_data
);

  import merge_pkg::*;

  merge_state_e state;         // handshake FSM
  merge_state_e state_nxt;
  chan_e        last_served;   // channel of the previous pick
  chan_e        pick;          // channel chosen this cycle
  logic         take;          // pop and capture this cycle

  // round-robin choice
  always_comb begin
    if (nempty0 && nempty1) begin
      pick = (last_served == ch0) ? ch1 : ch0;  // both ready, alternate
    end else if (nempty0) begin
      pick = ch0;
    end else begin
      pick = ch1;              // only meaningful when nempty1
    end
  end

  assign take = (state == idle) && (nempty0 || nempty1);
  assign re0  = take && (pick == ch0);
  assign re1  = take && (pick == ch1);

  assign out_req = (state == req_high);

  // four-phase sequencing
  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (take) begin
          state_nxt = req_high;              // req goes up next cycle
        end
      end
      req_high: begin
        if (out_ack) begin
          state_nxt = wait_ack_low;          // drop req after first ack
        end
      end
      wait_ack_low: begin
        if (!out_ack) begin
          state_nxt = idle;                  // ready to pick again
        end
      end
      default: begin
        state_nxt = idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= idle;
      last_served <= ch1;                    // first tie goes to ch0
    end else begin
      state <= state_nxt;
      if (take) begin
        last_served <= pick;
      end
    end
  end

  // output holding register, loaded on the pop cycle
  always_ff @(posedge clk) begin
    if (take) begin
      out_data <= (pick == ch0) ? data0 : data1;  // FIFO head is async
      out_chan <= pick;
    end
  end

  // data and tag must not move under a raised request
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_req |=> (!out_req || ($stable(out_data) && $stable(out_chan)))
  );

  // at most one FIFO popped per cycle
  a_one_read: assert property (
    @(posedge clk) disable iff (rst)
    !(re0 && re1)
  );

endmodule

/* verilog/dual_stream_merge.sv */
`timescale 1ns/1ps
// ##########################################################
// dual stream merge top
// two channel FIFOs side by side feeding one round-robin
// merger with a four-phase output to a single consumer
// ##########################################################

module dual_stream_merge (
  input  logic                              clk,
  input  logic                              rst,        // async, active high
  input  logic                              wr0,        // ch0 write strobe
  input  logic [merge_pkg::sample_width-1:0] wr_data0,  // ch0 sample
  input  logic                              wr1,        // ch1 write strobe
  input  logic [merge_pkg::sample_width-1:0] wr_data1,  // ch1 sample
  output logic                              out_req,    // sample offered
  input  logic                              out_ack,    // consumer answer
  output logic [merge_pkg::sample_width-1:0] out_data,  // merged sample
  output merge_pkg::chan_e                  out_chan,   // its source channel
  output logic                              overflow0,  // ch0 dropped a write
  output logic                              overflow1   // ch1 dropped a write
);

  import merge_pkg::*;

  logic                    re0;      // merger pops ch0
  logic                    re1;      // merger pops ch1
  logic                    nempty0;
  logic                    nempty1;
  logic [sample_width-1:0] data0;    // ch0 head word
  logic [sample_width-1:0] data1;    // ch1 head word

  fifo_1cycle #(.data_width(sample_width), .depth_log2(fifo_depth_log2)) fifo_ch0 (
    .clk(clk), .rst(rst),
    .we(wr0), .re(re0), .data_in(wr_data0), .data_out(data0),
    .nempty(nempty0), .overflow(overflow0)
  );

  fifo_1cycle #(.data_width(sample_width), .depth_log2(fifo_depth_log2)) fifo_ch1 (
    .clk(clk), .rst(rst),
    .we(wr1), .re(re1), .data_in(wr_data1), .data_out(data1),
    .nempty(nempty1), .overflow(overflow1)
  );

  channel_merger merger (
    .clk(clk), .rst(rst),
    .nempty0(nempty0), .nempty1(nempty1),
    .data0(data0), .data1(data1),
    .re0(re0), .re1(re1),
    .out_req(out_req), .out_ack(out_ack),
    .out_data(out_data), .out_chan(out_chan)
  );

endmodule

/* dv/merge_ref.svh */
// ##########################################################
// merge reference model
// expected samples per channel with their write cycle,
// round-robin channel prediction and an xorshift generator
// ##########################################################
`ifndef MERGE_REF_SVH
`define MERGE_REF_SVH

logic [sample_width-1:0] exp0_data[$];   // ch0 samples still owed
int                      exp0_stamp[$];  // cycle each ch0 sample was driven
logic [sample_width-1:0] exp1_data[$];   // ch1 samples still owed
int                      exp1_stamp[$];
chan_e                   ref_last_served = ch1;  // channel of the last delivery

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// channel the merger has to pick, -1 when nothing was visible
function automatic int predict_chan(input bit avail0, input bit avail1, input chan_e last);
  if (avail0 && avail1) begin
    return (last == ch0) ? 1 : 0;  // both waiting, the one not served last
  end else if (avail0) begin
    return 0;
  end else if (avail1) begin
    return 1;
  end
  return -1;
endfunction

task automatic push_expected(input chan_e ch, input logic [sample_width-1:0] d,
                             input int stamp);
  if (ch == ch0) begin
    exp0_data.push_back(d);
    exp0_stamp.push_back(stamp);
  end else begin
    exp1_data.push_back(d);
    exp1_stamp.push_back(stamp);
  end
endtask

`endif

/* dv/tb_dual_stream_merge.sv */
`timescale 1ns/1ps
// ##########################################################
// testbench for the dual stream merge
// random-gap sources, random-delay four-phase consumer and
// a checker against the per-channel reference queues
// ##########################################################

module tb_dual_stream_merge;

  import merge_pkg::*;

  `include "merge_ref.svh"

  logic                    clk;
  logic                    rst;
  logic                    wr0;
  logic [sample_width-1:0] wr_data0;
  logic                    wr1;
  logic [sample_width-1:0] wr_data1;
  logic                    out_req;
  logic                    out_ack;
  logic [sample_width-1:0] out_data;
  chan_e                   out_chan;
  logic                    overflow0;
  logic                    overflow1;

  int          cyc = 0;          // rising edges so far
  int          seq0 = 0;         // next ch0 sample value
  int          seq1 = 16'h8000;  // ch1 values kept apart from ch0
  logic [31:0] stim_rng = 32'h4c91;
  int          ack_max = 2;      // consumer delay range in cycles
  bit          ack_hold = 1'b0;  // consumer keeps ack low

  dual_stream_merge UUT (
    .clk(clk), .rst(rst), .wr0(wr0), .wr_data0(wr_data0), .wr1(wr1), .wr_data1(wr_data1),
    .out_req(out_req), .out_ack(out_ack), .out_data(out_data), .out_chan(out_chan),
    .overflow0(overflow0), .overflow1(overflow1)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;  // 4 ns period
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
    fail_now($sformatf("[ERROR] time %0t: %s expected %h, got %h", $time, sig, exp, got));
  endtask

  task automatic next_slot();
    @(posedge clk);
    #1;                               // inputs move just after the edge
  endtask

  task automatic settle_point();
    @(negedge clk);
    #1;                               // after the checker has looked
  endtask

  // one source cycle, a dropped ch1 write is not expected back
  task automatic source_cycle(input bit w0, input bit w1, input bit keep1);
    wr0      = w0;
    wr1      = w1;
    wr_data0 = sample_width'(seq0);
    wr_data1 = sample_width'(seq1);
    if (w0) begin
      push_expected(ch0, wr_data0, cyc);
      seq0++;
    end
    if (w1) begin
      if (keep1) begin
        push_expected(ch1, wr_data1, cyc);
      end
      seq1++;
    end
    next_slot();
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    settle_point();
    while (exp0_data.size() != 0 || exp1_data.size() != 0 || out_req || out_ack) begin
      if (n == limit) begin
        fail_now("timeout: samples still pending when waiting for the drain");
      end
      settle_point();
      n++;
    end
  endtask

  task automatic start_phase(input int max_delay, input bit hold);
    wait_drained(2000);
    ack_max  = max_delay;
    ack_hold = hold;
    next_slot();
  endtask

  // four-phase consumer with random ack delays
  initial begin : consumer
    logic [31:0] ack_rng;
    int          n;
    out_ack = 1'b0;
    ack_rng = xorshift32(32'h4c91);
    next_slot();
    forever begin
      n = 0;
      while (!out_req) begin
        if (n == 5000) fail_now("timeout: no request from the merger");
        next_slot();
        n++;
      end
      ack_rng = xorshift32(ack_rng);
      repeat (ack_rng % (ack_max + 1)) next_slot();
      n = 0;
      while (ack_hold) begin
        if (n == 5000) fail_now("timeout: ack held back too long");
        next_slot();
        n++;
      end
      out_ack = 1'b1;
      n = 0;
      while (out_req) begin
        if (n == 50) fail_now("timeout: out_req stayed high after out_ack");
        next_slot();
        n++;
      end
      ack_rng = xorshift32(ack_rng);
      repeat (ack_rng % (ack_max + 1)) next_slot();
      out_ack = 1'b0;
    end
  end

  // checks every offer and every handshake at the falling edge
  initial begin : compare
    bit                      busy;       // offer up, not yet withdrawn
    bit                      ack_prev;   // out_ack one check earlier
    bit                      avail0;
    bit                      avail1;
    int                      want;
    logic [sample_width-1:0] want_data;
    logic [sample_width-1:0] held_data;
    chan_e                   held_chan;
    busy     = 1'b0;
    ack_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (out_req && !busy) begin
          // pick was one cycle before req rose, it saw writes two edges back
          avail0 = exp0_data.size() != 0 && exp0_stamp[0] <= cyc - 2;
          avail1 = exp1_data.size() != 0 && exp1_stamp[0] <= cyc - 2;
          want   = predict_chan(avail0, avail1, ref_last_served);
          assert (want >= 0) else fail_now("delivery seen while no sample was pending");
          assert (out_chan == chan_e'(want)) else value_error("out_chan", want, out_chan);
          if (want == 0) begin
            want_data = exp0_data.pop_front();
            exp0_stamp.delete(0);
          end else begin
            want_data = exp1_data.pop_front();
            exp1_stamp.delete(0);
          end
          assert (out_data == want_data) else value_error("out_data", want_data, out_data);
          ref_last_served = chan_e'(want);
          held_data = out_data;
          held_chan = out_chan;
          busy      = 1'b1;
        end else if (out_req && busy) begin
          assert (out_data == held_data) else value_error("out_data", held_data, out_data);
          assert (out_chan == held_chan) else value_error("out_chan", held_chan, out_chan);
          assert (!ack_prev) else fail_now("out_req still high a cycle after out_ack");
        end else if (!out_req && busy) begin
          assert (ack_prev) else fail_now("out_req fell before out_ack was seen");
          busy = 1'b0;
        end
        ack_prev = out_ack;
      end
    end
  end

  initial begin : main
    rst      = 1'b1;
    wr0      = 1'b0;
    wr1      = 1'b0;
    wr_data0 = '0;
    wr_data1 = '0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    // ch0 alone, random gaps
    start_phase(2, 1'b0);
    for (int i = 0; i < 30; i++) begin
      source_cycle(1'b1, 1'b0, 1'b1);
      stim_rng = xorshift32(stim_rng);
      repeat (3 + stim_rng % 6) source_cycle(1'b0, 1'b0, 1'b0);
    end

    // both channels in the same cycles, slow consumer
    start_phase(6, 1'b0);
    repeat (12) source_cycle(1'b1, 1'b1, 1'b1);
    source_cycle(1'b0, 1'b0, 1'b0);

    // ch1 flood with ack held low, 16 survive
    start_phase(2, 1'b1);
    for (int i = 0; i < 20; i++) begin
      source_cycle(1'b0, 1'b1, i < 16);
    end
    repeat (3) source_cycle(1'b0, 1'b0, 1'b0);
    settle_point();
    assert (overflow1 == 1'b1) else value_error("overflow1", 1, overflow1);
    assert (overflow0 == 1'b0) else value_error("overflow0", 0, overflow0);
    ack_hold = 1'b0;

    wait_drained(2000);
    repeat (10) settle_point();       // no stray offer may follow
    assert (overflow0 == 1'b0) else value_error("overflow0", 0, overflow0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* compile.f */
+incdir+dv
verilog/merge_pkg.sv
verilog/fifo_1cycle.sv
verilog/channel_merger.sv
verilog/dual_stream_merge.sv
dv/tb_dual_stream_merge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dual stream merge testbench with Verilator
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
  --top-module tb_dual_stream_merge -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_dual_stream_merge
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

echo "simulation ended with status 0"
exit 0
